// File: sim.f
source/cacheConfigPkg.sv
source/cacheBusPkg.sv
source/dcacheController.sv
source/dcacheArray.sv
source/blockMemory.sv
source/dcacheTop.sv
dv/dcacheTop_properties.sv
dv/dcacheTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the data cache testbench under Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module dcacheTb -o dcacheSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcacheSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
exit 1

// File: dv/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb import cacheConfigPkg::*, cacheBusPkg::*; ();

	localparam int halfPeriod = 20;
	localparam int resetCycles = 10;
	// reset test, line reads, masked writes, eviction, random mix
	localparam int numAccesses = 1 + 8 + 12 + 3 + 200;
	localparam int cyclesPerAccess = 2 * memLatency + 8;
	localparam int marginCycles = 200;
	localparam int timeoutCycles = numAccesses * cyclesPerAccess + resetCycles + marginCycles;

	logic clock;
	logic reset;
	cpuRequest cpuReq;
	logic stall;
	logic [wordBits-1:0] readData;

	// reference image of main memory, keyed by word address
	logic [wordBits-1:0] shadow [int];
	// tag each set should hold under direct-mapped write-allocate
	logic [tagBits-1:0] residentTag [numSets];
	logic [numSets-1:0] residentValid;
	int errorCount;
	int checkCount;

	dcacheTop DUT (
		.clock(clock),
		.reset(reset),
		.cpuReq(cpuReq),
		.stall(stall),
		.readData(readData)
	);

	initial clock = 1'b0;
	always #halfPeriod clock = ~clock;

	// never-written words are the word address xor'd with C0DE0000
	function automatic logic [wordBits-1:0] expectedWord(input logic [addrBits-1:0] addr);
		if (shadow.exists(int'(addr))) begin
			return shadow[int'(addr)];
		end
		return {{(wordBits - addrBits){1'b0}}, addr} ^ 32'hC0DE_0000;
	endfunction

	function automatic void shadowWrite(input logic [addrBits-1:0] addr,
		input logic [wordBytes-1:0] sel, input logic [wordBits-1:0] data);
		logic [wordBits-1:0] word;
		word = expectedWord(addr);
		for (int b = 0; b < wordBytes; b++) begin
			if (sel[b]) begin
				word[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		shadow[int'(addr)] = word;
	endfunction

	task automatic checkWord(input logic [addrBits-1:0] addr, input logic [wordBits-1:0] expected,
		input logic [wordBits-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL readData at addr %h: expected %h actual %h", addr, expected, actual);
		end
	endtask

	task automatic checkStall(input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL stall: expected %h actual %h", expected, actual);
		end
	endtask

	task automatic plainError(input string what);
		errorCount++;
		$display("%s", what);
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("test %s finished, %0d mismatches", name, errorCount - startErrors);
	endtask

	// present one request at a falling edge and hold it until it completes
	task automatic access(input logic isWrite, input logic [addrBits-1:0] addr,
		input logic [wordBytes-1:0] sel, input logic [wordBits-1:0] data,
		output logic [wordBits-1:0] result, output int stallCycles);
		logic [indexBits-1:0] index;
		logic [tagBits-1:0] tag;
		logic expectMiss;
		index = addr[offsetBits +: indexBits];
		tag = addr[addrBits-1 -: tagBits];
		expectMiss = !residentValid[index] || (residentTag[index] != tag);
		cpuReq = '{read: !isWrite, write: isWrite, addr: addr, byteSelect: sel, writeData: data};
		stallCycles = 0;
		// a miss must hold stall high in the cycle it is presented
		#(halfPeriod / 2);
		checkStall(expectMiss, stall);
		@(negedge clock);
		while (stall) begin
			stallCycles++;
			@(negedge clock);
		end
		result = readData;
		// the rising edge after this sample still needs the request
		@(negedge clock);
		cpuReq = '0;
		if (isWrite) begin
			shadowWrite(addr, sel, data);
		end
		residentValid[index] = 1'b1;
		residentTag[index] = tag;
	endtask

	task automatic readCheck(input logic [addrBits-1:0] addr, output int stallCycles);
		logic [wordBits-1:0] data;
		access(1'b0, addr, '0, '0, data, stallCycles);
		checkWord(addr, expectedWord(addr), data);
	endtask

	task automatic testReset();
		int startErrors;
		int stalls;
		startErrors = errorCount;
		checkStall(1'b0, stall);
		readCheck(12'h025, stalls);
		if (stalls == 0) begin
			plainError("first read after reset completed without a miss");
		end
		reportTest("reset", startErrors);
	endtask

	task automatic testLineReads();
		int startErrors;
		int stalls;
		startErrors = errorCount;
		// line of 0x025 is resident after the reset test
		for (int pass = 0; pass < 2; pass++) begin
			for (int w = 0; w < blockWords; w++) begin
				readCheck(12'h024 + 12'(w), stalls);
				checkStall(1'b0, stalls != 0);
			end
		end
		reportTest("line reads", startErrors);
	endtask

	task automatic testByteWrites();
		int startErrors;
		int stalls;
		logic [wordBits-1:0] unused;
		startErrors = errorCount;
		for (int i = 0; i < 8; i++) begin
			access(1'b1, 12'h130 + 12'($urandom % blockWords), 4'($urandom), $urandom,
				unused, stalls);
		end
		for (int w = 0; w < blockWords; w++) begin
			readCheck(12'h130 + 12'(w), stalls);
		end
		reportTest("byte writes", startErrors);
	endtask

	task automatic testEviction();
		int startErrors;
		int stalls;
		logic [wordBits-1:0] unused;
		startErrors = errorCount;
		// same index, tags 01 and 21
		access(1'b1, 12'h048, 4'hF, 32'h5A5A_1234, unused, stalls);
		readCheck(12'h848, stalls);
		readCheck(12'h048, stalls);
		if (stalls == 0) begin
			plainError("read back of evicted line hit instead of refilling from memory");
		end
		reportTest("dirty eviction", startErrors);
	endtask

	task automatic testRandomMix();
		int startErrors;
		int stalls;
		logic [addrBits-1:0] addr;
		logic [wordBits-1:0] unused;
		startErrors = errorCount;
		for (int i = 0; i < 200; i++) begin
			// four tags over four sets keep the lines in conflict
			addr = {4'b0000, 2'($urandom), 2'b00, 2'($urandom), 2'($urandom)};
			if ($urandom % 2 == 0) begin
				readCheck(addr, stalls);
			end else begin
				access(1'b1, addr, 4'($urandom), $urandom, unused, stalls);
			end
		end
		reportTest("random mix", startErrors);
	endtask

	initial begin
		void'($urandom(32'ha721));
		errorCount = 0;
		checkCount = 0;
		residentValid = '0;
		reset = 1'b0;
		cpuReq = '0;
		repeat (resetCycles) @(negedge clock);
		reset = 1'b1;
		@(negedge clock);
		testReset();
		testLineReads();
		testByteWrites();
		testEviction();
		testRandomMix();
		$display("checks %0d, mismatches %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(timeoutCycles * 2 * halfPeriod);
		$display("run timed out after %0d cycles with accesses still pending", timeoutCycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: dv/dcacheTop_properties.sv
`timescale 1ns/1ps

module dcacheTopProperties import cacheBusPkg::*; (
	input logic clock,
	input logic reset,
	input cpuRequest cpuReq,
	input logic stall,
	input logic memRead,
	input logic memWrite,
	input memResponse memResp,
	input arrayControl arrayCtl
);

	// one memory operation at a time
	oneStrobe: assert property (@(posedge clock) disable iff (!reset)
		!(memRead && memWrite))
		else $error("memRead and memWrite high together");

	noRequestNoStall: assert property (@(posedge clock) disable iff (!reset)
		!(cpuReq.read || cpuReq.write) |-> !stall)
		else $error("stall high with no request");

	resetNoStall: assert property (@(posedge clock) $rose(reset) |-> !stall)
		else $error("stall high right after reset");

	// fill uses the block that arrived one cycle earlier
	fillAfterReady: assert property (@(posedge clock) disable iff (!reset)
		arrayCtl.fillWrite |-> $past(memResp.readReady))
		else $error("fill without readReady in the previous cycle");

	readHeld: assert property (@(posedge clock) disable iff (!reset)
		memRead && !memResp.readReady |=> memRead)
		else $error("memRead dropped before readReady");

	writeHeld: assert property (@(posedge clock) disable iff (!reset)
		memWrite && !memResp.writeDone |=> memWrite)
		else $error("memWrite dropped before writeDone");

endmodule

bind dcacheTop dcacheTopProperties props (
	.clock(clock),
	.reset(reset),
	.cpuReq(cpuReq),
	.stall(stall),
	.memRead(memRead),
	.memWrite(memWrite),
	.memResp(memResp),
	.arrayCtl(arrayCtl)
);

// File: source/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop import cacheConfigPkg::*, cacheBusPkg::*; (
	input logic clock,
	input logic reset,
	input cpuRequest cpuReq,
	output logic stall,
	output logic [wordBits-1:0] readData
);

	logic hit;
	logic dirty;
	logic writingBack;
	logic memRead;
	logic memWrite;
	arrayControl arrayCtl;
	logic [blockAddrBits-1:0] memBlockAddr;
	logic [blockBits-1:0] victimBlock;
	memRequest memReq;
	memResponse memResp;

	// strobes from the controller, address and data from the array
	assign memReq = '{
		read: memRead,
		write: memWrite,
		blockAddr: memBlockAddr,
		writeBlock: victimBlock
	};

	dcacheController controller (
		.clock(clock),
		.reset(reset),
		.request(cpuReq),
		.hit(hit),
		.dirty(dirty),
		.response(memResp),
		.stall(stall),
		.arrayCtl(arrayCtl),
		.memRead(memRead),
		.memWrite(memWrite),
		.writingBack(writingBack)
	);

	dcacheArray array (
		.clock(clock),
		.reset(reset),
		.request(cpuReq),
		.arrayCtl(arrayCtl),
		.writingBack(writingBack),
		.fillBlock(memResp.readBlock),
		.hit(hit),
		.dirty(dirty),
		.memBlockAddr(memBlockAddr),
		.victimBlock(victimBlock),
		.readData(readData)
	);

	blockMemory memory (
		.clock(clock),
		.reset(reset),
		.memRequest(memReq),
		.memResponse(memResp)
	);

endmodule

// File: source/blockMemory.sv
`timescale 1ns/1ps

module blockMemory import cacheConfigPkg::*; (
	input logic clock,
	input logic reset,
	input cacheBusPkg::memRequest memRequest,
	output cacheBusPkg::memResponse memResponse
);

	localparam int countBits = $clog2(memLatency + 1);

	logic [blockBits-1:0] memArray [memBlocks];
	logic [memBlocks-1:0] writtenBits;
	logic [blockBits-1:0] defaultBlock;
	logic [blockBits-1:0] image;
	logic [blockBits-1:0] readBlockReg;
	logic [countBits-1:0] countdown;
	logic busy;
	logic strobe;
	logic finishing;
	logic readReadyReg;
	logic writeDoneReg;

	assign strobe = memRequest.read | memRequest.write;
	assign finishing = busy && strobe && (countdown == countBits'(1));

	// unwritten lines follow the default word rule
	always_comb begin
		for (int w = 0; w < blockWords; w++) begin
			defaultBlock[w*wordBits +: wordBits] =
				defaultWord({memRequest.blockAddr, offsetBits'(w)});
		end
	end

	assign image = writtenBits[memRequest.blockAddr] ? memArray[memRequest.blockAddr]
		: defaultBlock;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			countdown <= '0;
			readReadyReg <= 1'b0;
			writeDoneReg <= 1'b0;
			writtenBits <= '0;
		end else begin
			readReadyReg <= 1'b0;
			writeDoneReg <= 1'b0;
			if (!busy) begin
				// strobe is still up during the done pulse
				if (strobe && !readReadyReg && !writeDoneReg) begin
					busy <= 1'b1;
					countdown <= countBits'(memLatency - 1);
				end
			end else if (!strobe) begin
				busy <= 1'b0;
			end else if (finishing) begin
				busy <= 1'b0;
				readReadyReg <= memRequest.read;
				writeDoneReg <= memRequest.write;
				if (memRequest.write) begin
					writtenBits[memRequest.blockAddr] <= 1'b1;
				end
			end else begin
				countdown <= countdown - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (finishing && memRequest.write) begin
			memArray[memRequest.blockAddr] <= memRequest.writeBlock;
		end
		// held until the next read completes
		if (finishing && memRequest.read) begin
			readBlockReg <= image;
		end
	end

	assign memResponse = '{
		readReady: readReadyReg,
		writeDone: writeDoneReg,
		readBlock: readBlockReg
	};

endmodule

// File: source/dcacheArray.sv
`timescale 1ns/1ps

module dcacheArray import cacheConfigPkg::*, cacheBusPkg::*; (
	input logic clock,
	input logic reset,
	input cpuRequest request,
	input arrayControl arrayCtl,
	input logic writingBack,
	input logic [blockBits-1:0] fillBlock,
	output logic hit,
	output logic dirty,
	output logic [blockAddrBits-1:0] memBlockAddr,
	output logic [blockBits-1:0] victimBlock,
	output logic [wordBits-1:0] readData
);

	logic [tagBits-1:0] tagMem [numSets];
	logic [blockBits-1:0] dataMem [numSets];
	logic [numSets-1:0] validBits;
	logic [numSets-1:0] dirtyBits;

	logic [tagBits-1:0] reqTag;
	logic [indexBits-1:0] reqIndex;
	logic [offsetBits-1:0] reqOffset;
	logic [wordBits-1:0] currentWord;
	logic [wordBits-1:0] mergedWord;
	logic wordWriteEn;
	logic fillEn;

	// split the word address
	assign reqTag = request.addr[addrBits-1 -: tagBits];
	assign reqIndex = request.addr[offsetBits +: indexBits];
	assign reqOffset = request.addr[offsetBits-1:0];

	assign wordWriteEn = arrayCtl.enable && arrayCtl.wordWrite;
	assign fillEn = arrayCtl.enable && arrayCtl.fillWrite;

	// lookup on the indexed line
	assign hit = validBits[reqIndex] && (tagMem[reqIndex] == reqTag);
	assign dirty = validBits[reqIndex] && dirtyBits[reqIndex];

	assign victimBlock = dataMem[reqIndex];
	assign currentWord = dataMem[reqIndex][reqOffset*wordBits +: wordBits];
	assign readData = currentWord;

	// victim address while writing back, requested block otherwise
	always_comb begin
		if (writingBack) begin
			memBlockAddr = {tagMem[reqIndex], reqIndex};
		end else begin
			memBlockAddr = {reqTag, reqIndex};
		end
	end

	// byte merge of the store into the addressed word
	always_comb begin
		for (int b = 0; b < wordBytes; b++) begin
			if (request.byteSelect[b]) begin
				mergedWord[b*8 +: 8] = request.writeData[b*8 +: 8];
			end else begin
				mergedWord[b*8 +: 8] = currentWord[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fillEn) begin
			dataMem[reqIndex] <= fillBlock;
			tagMem[reqIndex] <= reqTag;
		end else if (wordWriteEn) begin
			dataMem[reqIndex][reqOffset*wordBits +: wordBits] <= mergedWord;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (fillEn) begin
			// fresh line from memory is clean
			validBits[reqIndex] <= 1'b1;
			dirtyBits[reqIndex] <= 1'b0;
		end else if (wordWriteEn) begin
			dirtyBits[reqIndex] <= 1'b1;
		end
	end

endmodule

// File: source/dcacheController.sv
`timescale 1ns/1ps

module dcacheController import cacheBusPkg::*; (
	input logic clock,
	input logic reset,
	input cpuRequest request,
	input logic hit,
	input logic dirty,
	input memResponse response,
	output logic stall,
	output arrayControl arrayCtl,
	output logic memRead,
	output logic memWrite,
	output logic writingBack
);

	typedef enum logic [2:0] {
		IDLE,
		MISS,
		WRITEBACK,
		MEMREAD,
		FILL
	} cacheState;

	cacheState state;
	cacheState nextState;
	logic access;

	// read and write are never high together
	assign access = request.read | request.write;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (access && !hit) begin
					nextState = MISS;
				end
			end
			MISS: begin
				// victim must go out first if modified
				if (dirty) begin
					nextState = WRITEBACK;
				end else begin
					nextState = MEMREAD;
				end
			end
			WRITEBACK: begin
				if (response.writeDone) begin
					nextState = MEMREAD;
				end
			end
			MEMREAD: begin
				if (response.readReady) begin
					nextState = FILL;
				end
			end
			FILL: begin
				nextState = IDLE;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_comb begin
		stall = 1'b0;
		arrayCtl = '0;
		memRead = 1'b0;
		memWrite = 1'b0;
		writingBack = 1'b0;
		case (state)
			IDLE: begin
				// stall in the same cycle as the miss
				stall = access && !hit;
				if (access && hit) begin
					arrayCtl.enable = 1'b1;
					arrayCtl.wordWrite = request.write;
				end
			end
			MISS: begin
				stall = 1'b1;
			end
			WRITEBACK: begin
				stall = 1'b1;
				memWrite = 1'b1;
				writingBack = 1'b1;
			end
			MEMREAD: begin
				stall = 1'b1;
				memRead = 1'b1;
			end
			FILL: begin
				stall = 1'b1;
				arrayCtl.enable = 1'b1;
				arrayCtl.fillWrite = 1'b1;
			end
			default: begin
				stall = 1'b0;
			end
		endcase
	end

endmodule

// File: source/cacheBusPkg.sv
package cacheBusPkg;

	import cacheConfigPkg::*;

	// processor side, held steady while stall is high
	typedef struct packed {
		logic read;
		logic write;
		logic [addrBits-1:0] addr;
		logic [wordBytes-1:0] byteSelect;
		logic [wordBits-1:0] writeData;
	} cpuRequest;

	// read and write are levels held until the matching pulse
	typedef struct packed {
		logic read;
		logic write;
		logic [blockAddrBits-1:0] blockAddr;
		logic [blockBits-1:0] writeBlock;
	} memRequest;

	// readReady and writeDone are one-cycle pulses
	typedef struct packed {
		logic readReady;
		logic writeDone;
		logic [blockBits-1:0] readBlock;
	} memResponse;

	// controller commands to the array
	typedef struct packed {
		logic enable;
		logic wordWrite;
		logic fillWrite;
	} arrayControl;

endpackage

// File: source/cacheConfigPkg.sv
package cacheConfigPkg;

	// word geometry
	localparam int wordBytes = 4;
	localparam int wordBits = 32;

	// line geometry
	localparam int blockWords = 4;
	localparam int blockBits = 128;

	// word address = tag | index | offset
	localparam int offsetBits = 2;
	localparam int indexBits = 4;
	localparam int tagBits = 6;
	localparam int addrBits = 12;
	localparam int blockAddrBits = 10;

	localparam int numSets = 2 ** indexBits;
	localparam int memBlocks = 2 ** blockAddrBits;

	// cycles from strobe rise to done pulse
	localparam int memLatency = 4;

	// xor pattern for memory that was never written
	localparam logic [wordBits-1:0] defaultMask = 32'hC0DE_0000;

	// contents of a never-written word, from its word address
	function automatic logic [wordBits-1:0] defaultWord(input logic [addrBits-1:0] wordAddr);
		return wordBits'(wordAddr) ^ defaultMask;
	endfunction

endpackage
